/* source/fpu_defs.svh */
/* Format widths and array sizing for the FP16 add/subtract array.
   Included by the package and by each RTL module that needs a width. */

`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

`default_nettype none

// Half-precision exponent field.
`define FP16_EXPW 5

// Stored fraction, hidden bit not included.
`define FP16_FRACW 10

// Guard and round bits kept while aligning; sticky is an extra bit below them.
`define FPU_GUARDW 2

// Number of lanes, a power of two.
`define FPU_LANES 4

// Sequence tag, one value per lane.
`define FPU_TAGW $clog2(`FPU_LANES)

`default_nettype wire

`endif

/* source/fpuPkg.sv */
/* Shared types of the FP16 add array: the number format, the host request,
   the tagged request sent to a lane and the tagged lane result. */

`include "fpu_defs.svh"

`default_nettype none

package fpuPkg;

  // IEEE half precision, sign on top.
  typedef struct packed {
    logic                     sign;
    logic [`FP16_EXPW-1:0]    exp;
    logic [`FP16_FRACW-1:0]   frac;
  } fp16_t;

  // One host request, b gets its sign flipped when subtract is set.
  typedef struct packed {
    fp16_t a;
    fp16_t b;
    logic  subtract;
  } fpuOp_t;

  // Request plus its issue order tag.
  typedef struct packed {
    fpuOp_t               op;
    logic [`FPU_TAGW-1:0] tag;
  } fpuTaggedOp_t;

  // Lane result, tag selects the collector slot.
  typedef struct packed {
    fp16_t                value;
    logic [`FPU_TAGW-1:0] tag;
  } fpuResult_t;

  // One bit per lane.
  // Used for start strobes, idle levels and done strobes.
  typedef logic [`FPU_LANES-1:0] laneMask_t;

endpackage

`default_nettype wire

/* source/fpuDispatcher.sv */
/* Hands each host request to the lowest idle lane with a sequence tag.
   Counts operations in flight and raises busy when every tag is taken. */

`timescale 1ns/1ps

`include "fpu_defs.svh"

`default_nettype none

module fpuDispatcher (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 inValid,
  input  fpuPkg::fpuOp_t       inOp,
  input  fpuPkg::laneMask_t    laneIdle,
  input  logic                 retire,
  output logic                 busy,
  output fpuPkg::laneMask_t    laneStart,
  output fpuPkg::fpuTaggedOp_t laneOp
);
  import fpuPkg::*;

  logic [`FPU_TAGW-1:0] tagCount;
  logic [`FPU_TAGW:0]   inFlight;
  logic [`FPU_TAGW:0]   inFlightNext;
  logic                 issue;

  // A strobe under busy is dropped.
  assign issue = inValid & ~busy;

  // Lowest set idle bit wins.
  // Two's complement isolates it in one step.
  always_comb begin
    laneStart = '0;
    if (issue) begin
      laneStart = laneIdle & (~laneIdle + 1'b1);
    end
  end

  // Broadcast to every lane, only the started one captures it.
  always_comb begin
    laneOp.op  = inOp;
    laneOp.tag = tagCount;
  end

  // Issue adds one, retire removes one, both may happen together.
  always_comb begin
    inFlightNext = inFlight;
    if (issue && !retire) begin
      inFlightNext = inFlight + 1'b1;
    end else if (!issue && retire) begin
      inFlightNext = inFlight - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tagCount <= '0;
      inFlight <= '0;
      busy     <= 1'b0;
    end else begin
      // Tag wraps naturally at the lane count.
      if (issue) begin
        tagCount <= tagCount + 1'b1;
      end
      inFlight <= inFlightNext;
      // Registered so busy tracks the count in the same cycle.
      busy     <= (inFlightNext == `FPU_LANES);
    end
  end

endmodule

`default_nettype wire

/* source/fpuLane.sv */
/* One FP16 add/subtract lane: sorts and aligns with a true sticky bit, adds,
   then normalizes left one bit per cycle and truncates toward zero. */

`timescale 1ns/1ps

`include "fpu_defs.svh"

`default_nettype none

module fpuLane (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 start,
  input  fpuPkg::fpuTaggedOp_t op,
  output logic                 idle,
  output logic                 done,
  output fpuPkg::fpuResult_t   result
);
  import fpuPkg::*;

  localparam int ExpW   = `FP16_EXPW;
  localparam int FracW  = `FP16_FRACW;
  localparam int GuardW = `FPU_GUARDW;
  // Hidden bit plus fraction.
  localparam int MantW  = FracW + 1;
  // Bits kept above sticky after alignment.
  localparam int AlignW = MantW + GuardW;
  // Working significand, sticky in bit 0.
  localparam int SigW   = AlignW + 1;
  // Largest finite exponent.
  localparam int MaxExp = (1 << ExpW) - 2;

  typedef enum logic [2:0] {
    stIdle,
    stAlign,
    stAdd,
    stNorm,
    stDone
  } laneState_t;

  laneState_t   state;
  laneState_t   stateNext;
  fpuTaggedOp_t opReg;

  // Align stage, combinational.
  fp16_t             alA;
  fp16_t             alB;
  fp16_t             alLarge;
  fp16_t             alSmall;
  logic [ExpW-1:0]   expDiff;
  logic [ExpW-1:0]   alShift;
  logic [2*AlignW-1:0] alWide;
  logic [SigW-1:0]   alSmallSig;

  // Registered after ALIGN.
  logic [SigW-1:0]   largeSig;
  logic [SigW-1:0]   smallSig;
  logic              effSub;
  logic              resSign;
  logic [ExpW:0]     resExp;

  // Add stage, combinational.
  logic [SigW:0]     sum;
  logic [SigW-1:0]   addSig;
  logic [ExpW:0]     addExp;
  logic              addZero;
  logic              addNormed;

  // Normalize registers.
  logic [SigW-1:0]   normSig;
  logic              resZero;

  // Subnormals read as zero of the same sign.
  function automatic fp16_t flushSub(input fp16_t x);
    fp16_t y;
    y = x;
    if (x.exp == '0) begin
      y.frac = '0;
    end
    return y;
  endfunction

  always_comb begin
    alA = flushSub(opReg.op.a);
    alB = flushSub(opReg.op.b);
    // Subtract is an add with b negated.
    alB.sign = opReg.op.b.sign ^ opReg.op.subtract;

    // Larger magnitude goes first.
    if ({alA.exp, alA.frac} >= {alB.exp, alB.frac}) begin
      alLarge = alA;
      alSmall = alB;
    end else begin
      alLarge = alB;
      alSmall = alA;
    end

    expDiff = alLarge.exp - alSmall.exp;
    // Past AlignW everything lands in sticky anyway.
    alShift = (expDiff > AlignW) ? ExpW'(AlignW) : expDiff;

    alWide = {(alSmall.exp != '0), alSmall.frac, {GuardW{1'b0}}, {AlignW{1'b0}}} >> alShift;
    // Every bit shifted below the guard bits ORs into sticky.
    alSmallSig = {alWide[2*AlignW-1 -: AlignW], |alWide[AlignW-1:0]};
  end

  always_comb begin
    if (effSub) begin
      sum = {1'b0, largeSig} - {1'b0, smallSig};
    end else begin
      sum = {1'b0, largeSig} + {1'b0, smallSig};
    end

    addZero   = (sum == '0);
    addSig    = sum[SigW-1:0];
    addExp    = resExp;
    addNormed = sum[SigW] | sum[SigW-1];

    // Carry out: one step right, the lost bit folds into sticky.
    if (sum[SigW]) begin
      addSig = {sum[SigW:2], sum[1] | sum[0]};
      addExp = resExp + 1'b1;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      stIdle: begin
        if (start) begin
          stateNext = stAlign;
        end
      end
      stAlign: stateNext = stAdd;
      stAdd: begin
        // Zero, carry or already normal skips NORM.
        if (addZero || addNormed) begin
          stateNext = stDone;
        end else begin
          stateNext = stNorm;
        end
      end
      stNorm: begin
        // Ends on underflow or when this shift brings up the leading one.
        if (resExp <= 1 || normSig[SigW-2]) begin
          stateNext = stDone;
        end
      end
      stDone:  stateNext = stIdle;
      default: stateNext = stIdle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= stIdle;
    end else begin
      state <= stateNext;
    end
  end

  always_ff @(posedge clock) begin
    case (state)
      stIdle: begin
        if (start) begin
          opReg <= op;
        end
      end
      stAlign: begin
        largeSig <= {(alLarge.exp != '0), alLarge.frac, {GuardW{1'b0}}, 1'b0};
        smallSig <= alSmallSig;
        effSub   <= alLarge.sign ^ alSmall.sign;
        // Result takes the sign of the larger magnitude.
        resSign  <= alLarge.sign;
        resExp   <= {1'b0, alLarge.exp};
      end
      stAdd: begin
        normSig <= addSig;
        resExp  <= addExp;
        resZero <= addZero;
      end
      stNorm: begin
        if (resExp <= 1) begin
          // Below the smallest normal.
          resZero <= 1'b1;
        end else begin
          normSig <= normSig << 1;
          resExp  <= resExp - 1'b1;
        end
      end
      default: begin
      end
    endcase
  end

  assign idle = (state == stIdle);
  assign done = (state == stDone);

  // Truncation drops guard and sticky, which is round toward zero.
  always_comb begin
    result.tag = opReg.tag;
    if (resZero) begin
      // Zero and flushed results are always +0.
      result.value = '0;
    end else if (resExp > MaxExp) begin
      result.value.sign = resSign;
      result.value.exp  = ExpW'(MaxExp);
      result.value.frac = '1;
    end else begin
      result.value.sign = resSign;
      result.value.exp  = resExp[ExpW-1:0];
      result.value.frac = normSig[SigW-2 -: FracW];
    end
  end

endmodule

`default_nettype wire

/* source/fpuCollector.sv */
/* Reorder buffer for lane results. Each lane writes the slot named by its tag,
   and the head slot is emitted once full, so results leave in issue order. */

`timescale 1ns/1ps

`include "fpu_defs.svh"

`default_nettype none

module fpuCollector (
  input  logic              clock,
  input  logic              reset,
  input  fpuPkg::laneMask_t laneDone,
  input  fpuPkg::fpuResult_t laneResult [`FPU_LANES],
  output logic              outValid,
  output fpuPkg::fp16_t     outValue
);
  import fpuPkg::*;

  // One slot per tag.
  fp16_t                slotValue [`FPU_LANES];
  laneMask_t            slotFull;
  logic [`FPU_TAGW-1:0] headPtr;

  always_ff @(posedge clock) begin
    if (reset) begin
      slotFull <= '0;
      headPtr  <= '0;
      outValid <= 1'b0;
    end else begin
      outValid <= slotFull[headPtr];
      // Oldest result is ready, send it and move on.
      if (slotFull[headPtr]) begin
        slotFull[headPtr] <= 1'b0;
        headPtr           <= headPtr + 1'b1;
      end
      // A lane never holds the head tag while it is being emitted.
      for (int i = 0; i < `FPU_LANES; i++) begin
        if (laneDone[i]) begin
          slotFull[laneResult[i].tag] <= 1'b1;
        end
      end
    end
  end

  // Payload path.
  // One write port per lane since several can finish together.
  always_ff @(posedge clock) begin
    if (slotFull[headPtr]) begin
      outValue <= slotValue[headPtr];
    end
    for (int i = 0; i < `FPU_LANES; i++) begin
      if (laneDone[i]) begin
        slotValue[laneResult[i].tag] <= laneResult[i].value;
      end
    end
  end

endmodule

`default_nettype wire

/* source/fpuAddArray.sv */
/* Top of the FP16 add/subtract array. A dispatcher feeds a row of lanes and
   a collector returns their results to the host in request order. */

`timescale 1ns/1ps

`include "fpu_defs.svh"

`default_nettype none

module fpuAddArray (
  input  logic           clock,
  input  logic           reset,
  input  logic           inValid,
  input  fpuPkg::fpuOp_t inOp,
  output logic           busy,
  output logic           outValid,
  output fpuPkg::fp16_t  outValue
);
  import fpuPkg::*;

  laneMask_t    laneStart;
  laneMask_t    laneIdle;
  laneMask_t    laneDone;
  fpuTaggedOp_t laneOp;
  fpuResult_t   laneResult [`FPU_LANES];

  // Each emitted result retires one tag.
  fpuDispatcher uDispatcher (
    .clock     (clock),
    .reset     (reset),
    .inValid   (inValid),
    .inOp      (inOp),
    .laneIdle  (laneIdle),
    .retire    (outValid),
    .busy      (busy),
    .laneStart (laneStart),
    .laneOp    (laneOp)
  );

  for (genvar i = 0; i < `FPU_LANES; i++) begin : gLane
    fpuLane uLane (
      .clock  (clock),
      .reset  (reset),
      .start  (laneStart[i]),
      .op     (laneOp),
      .idle   (laneIdle[i]),
      .done   (laneDone[i]),
      .result (laneResult[i])
    );
  end

  fpuCollector uCollector (
    .clock      (clock),
    .reset      (reset),
    .laneDone   (laneDone),
    .laneResult (laneResult),
    .outValid   (outValid),
    .outValue   (outValue)
  );

endmodule

`default_nettype wire

/* sim/fpuAddArray_chk.sv */
/* Protocol checks for the FP16 add array, bound into the top level.
   Covers the busy rule, lane selection and the quiet output in reset. */

`timescale 1ns/1ps

`default_nettype none

module fpuAddArray_chk (
  input logic              clock,
  input logic              reset,
  input logic              inValid,
  input logic              busy,
  input logic              outValid,
  input fpuPkg::laneMask_t laneStart,
  input fpuPkg::laneMask_t laneIdle
);

  // Host holds off while every tag is in flight.
  noIssueWhileBusy: assert property (@(posedge clock) disable iff (reset) busy |-> !inValid)
    else $error("Request strobed while busy was high");

  // At most one lane starts per cycle.
  startOneHot: assert property (@(posedge clock) disable iff (reset) $onehot0(laneStart))
    else $error("More than one lane started in one cycle");

  // A busy lane is never picked.
  startIdleOnly: assert property (@(posedge clock) disable iff (reset)
    (laneStart & ~laneIdle) == '0)
    else $error("A lane was started while not idle");

  quietInReset: assert property (@(posedge clock) reset |=> !outValid)
    else $error("Result strobe seen during reset");

endmodule

bind fpuAddArray fpuAddArray_chk chk0 (
  .clock     (clock),
  .reset     (reset),
  .inValid   (inValid),
  .busy      (busy),
  .outValid  (outValid),
  .laneStart (laneStart),
  .laneIdle  (laneIdle)
);

`default_nettype wire

/* sim/fpuAddArrayTb.sv */
/* Testbench for the FP16 add/subtract array. Runs a directed table and then
   LFSR random operations, and checks every result against a reference model. */

`timescale 1ns/1ps

`default_nettype none

module fpuAddArrayTb;
  import fpuPkg::*;

  localparam int ClockPeriod = 4;
  localparam int NumDirected = 18;
  localparam int NumRandom   = 200;
  localparam int NumLanes    = $bits(laneMask_t);
  // Lane worst case is about 15 cycles, plus the collector and the idle cycle.
  localparam int WorstCycles = 20;
  localparam int TimeoutNs   = (NumDirected + NumRandom) * WorstCycles * 2 * ClockPeriod + 1000;
  // Every lane in flight at the end, each at its worst case.
  localparam int DrainCycles = NumLanes * WorstCycles;

  // One directed vector.
  typedef struct packed {
    logic [15:0] a;
    logic [15:0] b;
    logic        subtract;
    logic [15:0] expected;
  } vecRow_t;

  localparam vecRow_t DirTable [NumDirected] = '{
    {16'h3C00, 16'h3C00, 1'b0, 16'h4000},  // 1.0 + 1.0.
    {16'h3E00, 16'h3800, 1'b1, 16'h3C00},  // 1.5 - 0.5.
    {16'h3C00, 16'h4000, 1'b1, 16'hBC00},  // 1.0 - 2.0 flips the sign.
    {16'h3C00, 16'hBA00, 1'b1, 16'h3F00},  // Subtracting a negative.
    {16'h3C00, 16'h1000, 1'b0, 16'h3C00},  // 1.0 + 2^-11 truncates.
    {16'h3C00, 16'h0C00, 1'b1, 16'h3BFF},  // 1.0 - 2^-12 needs sticky.
    {16'h4248, 16'h4248, 1'b1, 16'h0000},  // x - x is +0.
    {16'h8000, 16'h8000, 1'b0, 16'h0000},  // -0 + -0 is +0 too.
    {16'h3C00, 16'h0001, 1'b0, 16'h3C00},  // Subnormal reads as zero.
    {16'h8200, 16'h3800, 1'b0, 16'h3800},
    {16'h0401, 16'h0400, 1'b1, 16'h0000},  // Tiny difference flushes.
    {16'h7BFF, 16'h7BFF, 1'b0, 16'h7BFF},  // Saturates.
    {16'hFBFF, 16'h7BFF, 1'b1, 16'hFBFF},
    {16'h3C01, 16'h3C00, 1'b1, 16'h1400},  // Long normalize, then short ones.
    {16'h3C00, 16'h3C00, 1'b0, 16'h4000},
    {16'h47FF, 16'h47FE, 1'b1, 16'h1C00},
    {16'h3800, 16'h3800, 1'b0, 16'h3C00},
    {16'h0000, 16'h0000, 1'b1, 16'h0000}
  };

  logic   clock;
  logic   reset;
  logic   inValid;
  fpuOp_t inOp;
  logic   busy;
  logic   outValid;
  fp16_t  outValue;

  fp16_t       expQ[$];
  fpuOp_t      opQ[$];
  int          issued = 0;
  int          returned = 0;
  int          inFlight;
  int          drainCount;
  logic [31:0] lfsrState = 32'ha787f402;
  fpuOp_t      doneOp;
  fp16_t       doneExp;
  fpuOp_t      nextOp;
  vecRow_t     row;

  fpuAddArray dut0 (
    .clock    (clock),
    .reset    (reset),
    .inValid  (inValid),
    .inOp     (inOp),
    .busy     (busy),
    .outValid (outValid),
    .outValue (outValue)
  );

  initial begin
    clock = 1'b0;
    forever #(ClockPeriod / 2) clock = ~clock;
  end

  task automatic stopRun();
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic checkValue(input fp16_t got, input fp16_t expected, input string what);
    if (got !== expected) begin
      $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, expected);
      stopRun();
    end
  endtask

  task automatic checkBusy(input logic got, input logic expected, input string what);
    if (got !== expected) begin
      $display("MISMATCH at %0t: %s, got %b expected %b", $time, what, got, expected);
      stopRun();
    end
  endtask

  task automatic checkCount(input int got, input int expected, input string what);
    if (got != expected) begin
      $display("MISMATCH at %0t: %s, got %0d expected %0d", $time, what, got, expected);
      stopRun();
    end
  endtask

  // Galois LFSR stepped once per bit handed out.
  function automatic logic lfsrBit();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit) begin
      lfsrState = lfsrState ^ 32'h80200003;
    end
    return outBit;
  endfunction

  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsrBit()};
    end
    return v;
  endfunction

  // Draw again on exponent 31, which would mean infinity or NaN.
  function automatic fp16_t randomOperand();
    fp16_t x;
    x.exp = 5'd31;
    while (x.exp == 5'd31) begin
      x.sign = takeBits(1) != 0;
      x.exp  = 5'(takeBits(5));
    end
    x.frac = 10'(takeBits(10));
    return x;
  endfunction

  // Signed value in units of 2^-24. Subnormals count as zero.
  function automatic longint scaledValue(input fp16_t x, input logic negate);
    longint mag;
    mag = 0;
    if (x.exp != 0) begin
      mag = longint'({1'b1, x.frac}) << (x.exp - 1);
    end
    return (x.sign ^ negate) ? -mag : mag;
  endfunction

  // Exact sum, then truncate, flush or saturate.
  function automatic fp16_t modelAddSub(input fpuOp_t op);
    longint total;
    longint mag;
    int     lead;
    int     e;
    fp16_t  r;
    total = scaledValue(op.a, 1'b0) + scaledValue(op.b, op.subtract);
    mag   = (total < 0) ? -total : total;
    r     = '0;
    if (mag == 0) begin
      return r;
    end
    lead = 63;
    while (mag[lead] == 1'b0) begin
      lead--;
    end
    // Leading one at bit e+9 for biased exponent e.
    e = lead - 9;
    if (e < 1) begin
      return r;
    end
    r.sign = (total < 0);
    if (e > 30) begin
      r.exp  = 5'd30;
      r.frac = '1;
    end else begin
      r.exp  = 5'(e);
      r.frac = 10'(mag >> (lead - 10));
    end
    return r;
  endfunction

  // Waits out busy, then strobes one request for a cycle.
  task automatic issueOp(input fpuOp_t op, input fp16_t expected);
    while (busy) begin
      @(posedge clock);
      #1;
    end
    inValid = 1'b1;
    inOp    = op;
    expQ.push_back(expected);
    opQ.push_back(op);
    issued++;
    @(posedge clock);
    #1;
    inValid = 1'b0;
  endtask

  // Outputs are sampled half a cycle after they change.
  always @(negedge clock) begin
    if (!reset) begin
      // This cycle's strobe and this cycle's result are not yet counted by the DUT.
      inFlight = issued - int'(inValid) - returned;
      checkBusy(busy, inFlight == NumLanes,
                $sformatf("busy with %0d requests in flight", inFlight));
      if (outValid) begin
        if (expQ.size() == 0) begin
          $display("A result came back with no request outstanding at %0t", $time);
          stopRun();
        end else begin
          doneExp = expQ.pop_front();
          doneOp  = opQ.pop_front();
          checkValue(outValue, doneExp, $sformatf("result %0d of %h %s %h", returned,
                     doneOp.a, doneOp.subtract ? "-" : "+", doneOp.b));
          returned++;
        end
      end
    end
  end

  initial begin
    #(TimeoutNs);
    $display("Watchdog expired with %0d of %0d results returned", returned, issued);
    stopRun();
  end

  initial begin
    reset   = 1'b1;
    inValid = 1'b0;
    inOp    = '0;
    repeat (10) @(posedge clock);
    #1;
    reset = 1'b0;

    for (int i = 0; i < NumDirected; i++) begin
      row = DirTable[i];
      nextOp.a        = row.a;
      nextOp.b        = row.b;
      nextOp.subtract = row.subtract;
      // The model must agree with the hand-worked table.
      checkValue(modelAddSub(nextOp), row.expected, $sformatf("model on table row %0d", i));
      issueOp(nextOp, row.expected);
    end

    for (int i = 0; i < NumRandom; i++) begin
      nextOp.a = randomOperand();
      nextOp.b = randomOperand();
      // One in four shares the exponent, for heavy cancellation.
      if (takeBits(2) == 0) begin
        nextOp.b.exp = nextOp.a.exp;
      end
      nextOp.subtract = takeBits(1) != 0;
      issueOp(nextOp, modelAddSub(nextOp));
    end

    // Give the last results time to come back.
    drainCount = 0;
    while (returned < issued && drainCount < DrainCycles) begin
      @(posedge clock);
      drainCount++;
    end
    // Extra results would show up here.
    repeat (20) @(posedge clock);
    checkCount(returned, issued, "returned results against issued requests");
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+source
source/fpuPkg.sv
source/fpuDispatcher.sv
source/fpuLane.sv
source/fpuCollector.sv
source/fpuAddArray.sv
sim/fpuAddArray_chk.sv
sim/fpuAddArrayTb.sv

/* run.sh */
#!/bin/sh
# Builds the FP16 add array testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f sources.f \
  --top-module fpuAddArrayTb \
  -Mdir obj_dir \
  -o simv
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/simv
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation finished cleanly"
exit 0
